//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vdc -f sources.f -o tb_vdc \
	&& ./obj_dir/tb_vdc > sim.log 2>&1 \
	|| { echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sources.f
vdc_reg_pkg.sv
vdc_video_pkg.sv
vdc_vram.sv
vdc_line_buf.sv
vdc_regs.sv
vdc_timing.sv
vdc_fetch_fsm.sv
vdc_pixel_out.sv
vdc_top.sv
vdc_chk.sv
tb_vdc.sv

//--- tb_vdc.sv
/* Display controller testbench */
`timescale 1ns/10ps

module tb_vdc;

	localparam int max_ops = 64;
	localparam int wait_limit = 20000; // Clocks per wait, well above one frame
	localparam logic [3:0] fg_col = 4'h9;
	localparam logic [3:0] bg_col = 4'he;

	logic clk = 1'b0;
	logic reset, cs, rs, we, lp_n;
	logic [7:0] db_in, db_out;
	vdc_video_pkg::rgbi_t rgbi;
	logic hsync, vsync, hblank, vblank;

	logic [15:0] stim [3*max_ops];  // op, addr, value triples
	logic [7:0]  code_mem [32];     // Screen codes, row*8+col
	logic [7:0]  glyph_mem [256][4]; // Glyph lines by code
	logic [31:0] lfsr;
	int errors, tests_run, tests_failed, errs_before, test_no;
	bit timed_out;
	int next_ua; // Address the data latch will hold next, -1 if unknown

	vdc_top dut_i (
		.clk(clk), .reset(reset), .cs(cs), .rs(rs), .we(we), .lp_n(lp_n),
		.db_in(db_in), .db_out(db_out), .rgbi(rgbi), .hsync(hsync),
		.vsync(vsync), .hblank(hblank), .vblank(vblank)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32,22,2,1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_bit()};
		end
		return b;
	endfunction

	function automatic logic sig_value(input int sel);
		case (sel)
			0: return hsync;
			1: return vsync;
			2: return hblank;
			default: return vblank;
		endcase
	endfunction

	task automatic note_timeout(input string what);
		if (!timed_out) begin
			$display("Timeout at %0t ns: %s did not happen in time", $time, what);
		end
		timed_out = 1'b1;
		errors++;
	endtask

	task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s gave %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input logic r, input logic [7:0] d);
		@(negedge clk);
		cs = 1'b1;
		we = 1'b1;
		rs = r;
		db_in = d;
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_read(input logic r, output logic [7:0] d);
		@(negedge clk);
		cs = 1'b1;
		we = 1'b0;
		rs = r;
		@(negedge clk);
		cs = 1'b0;
		d = db_out; // Loaded at the edge in between
	endtask

	task automatic reg_write(input logic [5:0] sel, input logic [7:0] v);
		bus_write(1'b0, {2'b00, sel});
		bus_write(1'b1, v);
	endtask

	task automatic reg_read(input logic [5:0] sel, output logic [7:0] v);
		bus_write(1'b0, {2'b00, sel});
		bus_read(1'b1, v);
	endtask

	// Poll the ready bit of the status byte
	task automatic wait_ready();
		logic [7:0] st;
		for (int n = 0; n < wait_limit; n++) begin
			if (timed_out) return;
			bus_read(1'b0, st);
			if (st[vdc_reg_pkg::st_ready]) return;
		end
		note_timeout("status ready");
	endtask

	// Counts falling edges until the output reaches the level
	task automatic wait_level(input int sel, input logic level, output int cycles);
		cycles = 0;
		while (sig_value(sel) !== level) begin
			if (timed_out) return;
			if (cycles >= wait_limit) begin
				note_timeout("sync or blank edge");
				return;
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic set_ua(input logic [15:0] a);
		wait_ready();
		reg_write(vdc_reg_pkg::reg_ua_hi, a[15:8]);
		reg_write(vdc_reg_pkg::reg_ua_lo, a[7:0]);
		bus_write(1'b0, {2'b00, vdc_reg_pkg::reg_data}); // Data port stays selected
	endtask

	task automatic data_write(input logic [7:0] b);
		bus_write(1'b1, b);
		wait_ready();
	endtask

	task automatic begin_test();
		errs_before = errors;
		test_no++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors > errs_before) begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", test_no, name, errors - errs_before);
		end else begin
			$display("Test %0d %s: passed", test_no, name);
		end
	endtask

	initial begin
		int k, cyc, hi_cyc, lo_cyc;
		logic [15:0] op, a, v;
		logic [7:0] d, hi, lo, code, g;
		logic [3:0] exp_pix;
		bit ram_phase;
		reset = 1'b1;
		cs = 1'b0;
		rs = 1'b0;
		we = 1'b0;
		lp_n = 1'b0;
		db_in = 8'h00;
		lfsr = 32'hbc0f_cde7;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_no = 0;
		timed_out = 1'b0;
		next_ua = -1;
		ram_phase = 1'b0;
		for (int i = 0; i < 3*max_ops; i++) begin
			stim[i] = '0;
		end
		$readmemh("vdc_stim.txt", stim);
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// Register readback, then RAM through the update address
		begin_test();
		for (k = 0; k < max_ops; k++) begin
			op = stim[3*k];
			a = stim[3*k+1];
			v = stim[3*k+2];
			if (op == 16'd0) break;
			if (op >= 16'd3 && !ram_phase) begin
				end_test("register readback");
				begin_test();
				ram_phase = 1'b1;
			end
			case (op)
				16'd1: begin
					reg_write(a[5:0], v[7:0]);
					next_ua = -1;
				end
				16'd2: begin
					reg_read(a[5:0], d);
					check_val("register read", {8'h00, d}, v);
					next_ua = -1;
				end
				16'd3: begin
					set_ua(a);
					data_write(v[7:0]);
					reg_read(vdc_reg_pkg::reg_ua_hi, hi);
					reg_read(vdc_reg_pkg::reg_ua_lo, lo);
					check_val("update address after write", {hi, lo}, a + 16'd1);
					next_ua = -1;
				end
				default: begin
					if (int'(a) != next_ua) begin
						set_ua(a);
						bus_read(1'b1, d); // Dummy read fills the latch
					end
					wait_ready();
					bus_read(1'b1, d);
					check_val("RAM read", {8'h00, d}, v);
					next_ua = int'(a) + 1;
				end
			endcase
		end
		end_test("RAM access");
		wait_ready();

		// Raster with ht=15 hd=8 hp=10 hw=2 ctv=3 vt=5 vd=4 vp=4 vw=1
		begin_test();
		@(negedge clk);
		wait_level(0, 1'b0, cyc);
		wait_level(0, 1'b1, cyc);
		wait_level(0, 1'b0, hi_cyc);
		wait_level(0, 1'b1, lo_cyc);
		check_val("hsync width", 16'(hi_cyc), 16'd16);
		check_val("hsync period", 16'(hi_cyc + lo_cyc), 16'd128);
		wait_level(2, 1'b1, cyc);
		wait_level(2, 1'b0, cyc);
		wait_level(2, 1'b1, lo_cyc);
		check_val("hblank low time", 16'(lo_cyc), 16'd64);
		wait_level(1, 1'b0, cyc);
		wait_level(1, 1'b1, cyc);
		wait_level(1, 1'b0, hi_cyc);
		wait_level(1, 1'b1, lo_cyc);
		check_val("vsync period", 16'(hi_cyc + lo_cyc), 16'd3072);
		end_test("raster timing");

		// Pixels from random glyphs at 0x1000 and codes at address 0
		begin_test();
		reg_write(vdc_reg_pkg::reg_colour, {fg_col, bg_col});
		reg_write(vdc_reg_pkg::reg_cb, 8'h20);
		set_ua(16'h0000);
		for (int i = 0; i < 32; i++) begin
			code_mem[i] = 8'h10 + 8'(i);
			data_write(code_mem[i]);
		end
		for (int i = 0; i < 32; i++) begin
			code = code_mem[i];
			set_ua(16'h1000 + {4'h0, code, 4'h0});
			for (int ln = 0; ln < 4; ln++) begin
				glyph_mem[code][ln] = rand_byte();
				data_write(glyph_mem[code][ln]);
			end
		end
		@(negedge clk);
		wait_level(3, 1'b1, cyc);
		wait_level(3, 1'b0, cyc); // Row 0 line 0 starts here
		for (k = 0; k < 16 && !timed_out; k++) begin
			if (k > 0) begin
				wait_level(2, 1'b1, cyc);
				wait_level(2, 1'b0, cyc);
			end
			for (int p = 0; p < 64; p++) begin
				code = code_mem[(k/4)*8 + p/8];
				g = glyph_mem[code][k%4];
				exp_pix = g[7 - p%8] ? fg_col : bg_col;
				if (rgbi !== exp_pix) begin
					$display("[FAIL] %0t ns: line %0d pixel %0d rgbi %h, expected %h",
						$time, k, p, rgbi, exp_pix);
					errors++;
				end
				@(negedge clk);
			end
		end
		end_test("pixel output");

		// Light pen at row 1 line 1, column 3
		begin_test();
		@(negedge clk);
		wait_level(3, 1'b1, cyc);
		wait_level(3, 1'b0, cyc); // Counters are 2 pixels ahead of the outputs
		repeat (5*128 + 3*8) @(negedge clk);
		lp_n = 1'b1;
		repeat (4) @(negedge clk);
		lp_n = 1'b0;
		for (k = 0; k < 100; k++) begin
			bus_read(1'b0, d);
			if (d[vdc_reg_pkg::st_lp]) break;
		end
		if (k == 100) begin
			note_timeout("light pen flag");
		end
		reg_read(vdc_reg_pkg::reg_lpv, d);
		check_val("light pen row", {8'h00, d}, 16'd1);
		reg_read(vdc_reg_pkg::reg_lph, d);
		if (d < 8'd2 || d > 8'd4) begin
			$display("[FAIL] %0t ns: light pen column %0d, expected 3 within 1", $time, d);
			errors++;
		end
		bus_read(1'b0, d);
		check_val("light pen flag after read", {15'h0, d[vdc_reg_pkg::st_lp]}, 16'd0);
		end_test("light pen");

		// Vertical blank bit, away from the edges
		begin_test();
		@(negedge clk);
		wait_level(3, 1'b1, cyc);
		repeat (10) @(negedge clk);
		bus_read(1'b0, d);
		check_val("status vblank in blank", {15'h0, d[vdc_reg_pkg::st_vblank]}, 16'd1);
		wait_level(3, 1'b0, cyc);
		repeat (10) @(negedge clk);
		bus_read(1'b0, d);
		check_val("status vblank in display", {15'h0, d[vdc_reg_pkg::st_vblank]}, 16'd0);
		end_test("status vblank");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- vdc_chk.sv
/* Bus and video checks */
`timescale 1ns/10ps

module vdc_chk #(
	parameter int ram_addr_bits = 14
)(
	input logic                     clk,
	input logic                     reset,
	input logic                     req_valid,
	input logic                     req_ready,
	input logic                     req_write,
	input logic [ram_addr_bits-1:0] req_addr,
	input logic [7:0]               req_data,
	input logic                     rsp_valid,
	input logic [3:0]               rgbi,
	input logic                     hblank,
	input logic                     vblank
);

	// Stalled request holds still
	req_hold: assert property (@(posedge clk) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable({req_write, req_addr, req_data}))
		else $error("RAM request changed while stalled");

	// Read data two clocks after the transfer
	rsp_delay: assert property (@(posedge clk) disable iff (reset)
		req_valid && req_ready && !req_write |-> ##2 rsp_valid)
		else $error("Read response missing two clocks after the transfer");

	blank_black: assert property (@(posedge clk) disable iff (reset)
		(hblank || vblank) |-> rgbi == 4'h0)
		else $error("Colour output during blanking");

endmodule

bind vdc_top vdc_chk #(.ram_addr_bits(ram_addr_bits)) chk_i (
	.clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
	.req_write(req_write), .req_addr(req_addr), .req_data(req_data),
	.rsp_valid(rsp_valid), .rgbi(rgbi), .hblank(hblank), .vblank(vblank)
);

//--- vdc_fetch_fsm.sv
/* Video RAM arbiter and line fetch */
`timescale 1ns/10ps

module vdc_fetch_fsm #(
	parameter int ram_addr_bits = 14,
	parameter int max_cols = 32
)(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        line_start,
	input  logic [4:0]                  next_line,
	input  logic [7:0]                  next_row,
	input  logic [7:0]                  hd,
	input  logic [15:0]                 ds,
	input  logic [2:0]                  cb,
	input  logic                        req_valid,
	input  logic                        req_write,
	input  logic [ram_addr_bits-1:0]    req_addr,
	input  logic [7:0]                  req_data,
	output logic                        req_ready,
	output logic                        rsp_valid,
	output logic [7:0]                  rsp_data,
	output logic                        code_wr,
	output logic                        bmp_wr,
	output logic [$clog2(max_cols)-1:0] wr_idx,
	output logic [$clog2(max_cols)-1:0] code_idx,
	output logic [7:0]                  wr_data,
	input  vdc_video_pkg::code_t        code_rd
);

	typedef enum logic [2:0] {st_idle, st_cpu, st_code, st_bmp, st_rsp} state_t;

	state_t                   state;
	logic [7:0]               cnt;        // Column being fetched
	logic                     fetch_pend; // line_start seen while busy
	logic                     issue;      // RAM read for a column this cycle
	logic [15:0]              row_base;
	logic [15:0]              code_addr;
	logic [3:0]               glyph_line;
	logic                     cpu_write;
	logic [ram_addr_bits-1:0] cpu_addr;
	logic [7:0]               cpu_data;
	logic                     ram_we;
	logic [ram_addr_bits-1:0] ram_addr;
	logic [7:0]               ram_rdata;

	assign req_ready = (state == st_idle) && !line_start && !fetch_pend;
	assign rsp_valid = state == st_rsp; // Two clocks after the transfer
	assign rsp_data = ram_rdata;
	assign wr_data = ram_rdata;
	assign code_idx = cnt[$clog2(max_cols)-1:0];
	assign issue = (state == st_code || state == st_bmp) && (cnt < hd);
	assign code_addr = row_base + {8'h00, cnt};

	always_comb begin
		ram_we = 1'b0;
		ram_addr = cpu_addr;
		case (state)
			st_cpu:  ram_we = cpu_write;
			st_code: ram_addr = code_addr[ram_addr_bits-1:0];
			st_bmp:  ram_addr = ram_addr_bits'({cb[0], code_rd, glyph_line}); // Glyph row
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			fetch_pend <= 1'b0;
			code_wr <= 1'b0;
			bmp_wr <= 1'b0;
		end else begin
			code_wr <= issue && (state == st_code); // Data arrives a clock later
			bmp_wr <= issue && (state == st_bmp);
			if (line_start && state != st_idle) begin
				fetch_pend <= 1'b1;
			end
			case (state)
				st_idle: begin
					if (line_start || fetch_pend) begin
						state <= st_code;
						cnt <= '0;
						fetch_pend <= 1'b0;
					end else if (req_valid) begin
						state <= st_cpu;
					end
				end
				st_cpu: state <= cpu_write ? st_idle : st_rsp;
				st_rsp: state <= st_idle;
				st_code: begin
					if (cnt == hd) begin // One spare clock lets the last code land
						state <= st_bmp;
						cnt <= '0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				st_bmp: begin
					cnt <= cnt + 8'd1;
					if ({1'b0, cnt} + 9'd1 >= {1'b0, hd}) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		wr_idx <= cnt[$clog2(max_cols)-1:0];
		if (state == st_idle && (line_start || fetch_pend)) begin
			row_base <= ds + next_row * hd;
			glyph_line <= next_line[3:0];
		end
		if (req_valid && req_ready) begin
			cpu_write <= req_write;
			cpu_addr <= req_addr;
			cpu_data <= req_data;
		end
	end

	vdc_vram #(
		.ram_addr_bits(ram_addr_bits)
	) vram_i (
		.clk(clk),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(cpu_data),
		.rdata(ram_rdata)
	);

endmodule

//--- vdc_line_buf.sv
/* Per-column line buffer */
`timescale 1ns/10ps

module vdc_line_buf #(
	parameter type item_t = logic [7:0],
	parameter int max_cols = 32
)(
	input  logic                        clk,
	input  logic                        wr_en,
	input  logic [$clog2(max_cols)-1:0] wr_idx,
	input  item_t                       wr_data,
	input  logic [$clog2(max_cols)-1:0] rd_idx,
	output item_t                       rd_data
);

	item_t mem [max_cols];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

	assign rd_data = mem[rd_idx]; // Same-cycle read

endmodule

//--- vdc_pixel_out.sv
/* Pixel output pipeline */
`timescale 1ns/10ps

module vdc_pixel_out (
	input  logic                   clk,
	input  logic                   reset,
	input  vdc_video_pkg::pixel_t  pixel,
	input  logic                   hvis,
	input  logic                   vvis,
	input  logic                   hsync_raw,
	input  logic                   vsync_raw,
	input  vdc_video_pkg::bitmap_t bmp,
	input  vdc_video_pkg::rgbi_t   fg,
	input  vdc_video_pkg::rgbi_t   bg,
	output vdc_video_pkg::rgbi_t   rgbi,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   hblank,
	output logic                   vblank
);

	logic bit_s1;  // Selected glyph bit
	logic hvis_s1;
	logic vvis_s1;
	logic hs_s1;
	logic vs_s1;

	always_ff @(posedge clk) begin
		if (reset) begin
			{bit_s1, hvis_s1, vvis_s1, hs_s1, vs_s1} <= '0;
			{hsync, vsync, hblank, vblank} <= '0;
			rgbi <= '0;
		end else begin
			bit_s1 <= bmp[vdc_video_pkg::char_width - 1 - pixel]; // MSB is leftmost
			hvis_s1 <= hvis;
			vvis_s1 <= vvis;
			hs_s1 <= hsync_raw;
			vs_s1 <= vsync_raw;
			hsync <= hs_s1;
			vsync <= vs_s1;
			hblank <= !hvis_s1;
			vblank <= !vvis_s1;
			if (!hvis_s1 || !vvis_s1) begin
				rgbi <= '0; // Black in blanking
			end else begin
				rgbi <= bit_s1 ? fg : bg;
			end
		end
	end

endmodule

//--- vdc_reg_pkg.sv
/* Display controller register map */
package vdc_reg_pkg;

	localparam logic [5:0] reg_ht     = 6'd0;  // Horizontal total, minus 1
	localparam logic [5:0] reg_hd     = 6'd1;  // Horizontal displayed
	localparam logic [5:0] reg_hp     = 6'd2;  // Horizontal sync position
	localparam logic [5:0] reg_sw     = 6'd3;  // Sync widths, vertical high and horizontal low
	localparam logic [5:0] reg_vt     = 6'd4;  // Vertical total in rows, minus 1
	localparam logic [5:0] reg_vd     = 6'd6;  // Vertical displayed rows
	localparam logic [5:0] reg_vp     = 6'd7;  // Vertical sync row
	localparam logic [5:0] reg_ctv    = 6'd9;  // Scan lines per row, minus 1
	localparam logic [5:0] reg_ds_hi  = 6'd12; // Display start, high byte
	localparam logic [5:0] reg_ds_lo  = 6'd13; // Display start, low byte
	localparam logic [5:0] reg_lpv    = 6'd16; // Light pen row
	localparam logic [5:0] reg_lph    = 6'd17; // Light pen column
	localparam logic [5:0] reg_ua_hi  = 6'd18; // Update address, high byte
	localparam logic [5:0] reg_ua_lo  = 6'd19; // Update address, low byte
	localparam logic [5:0] reg_colour = 6'd26; // Foreground high, background low
	localparam logic [5:0] reg_cb     = 6'd28; // Character set base in bits 7..5
	localparam logic [5:0] reg_data   = 6'd31; // Video RAM data port

	// Bits that do not exist read back as 1
	localparam logic [7:0] read_mask [64] = '{
		reg_ht: 8'h00, reg_hd: 8'h00, reg_hp: 8'h00, reg_sw: 8'h00,
		reg_vt: 8'h00, reg_vd: 8'h00, reg_vp: 8'h00, reg_ctv: 8'he0,
		reg_ds_hi: 8'h00, reg_ds_lo: 8'h00, reg_lpv: 8'h00, reg_lph: 8'h00,
		reg_ua_hi: 8'h00, reg_ua_lo: 8'h00, reg_colour: 8'h00, reg_cb: 8'h1f,
		reg_data: 8'h00,
		default: 8'hff
	};

	localparam int st_ready  = 7; // Set when no RAM access is pending
	localparam int st_lp     = 6; // Light pen position captured
	localparam int st_vblank = 5; // Vertical blanking

endpackage

//--- vdc_regs.sv
/* Bus interface and register file */
`timescale 1ns/10ps

module vdc_regs #(
	parameter int ram_addr_bits = 14
)(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cs,
	input  logic                     rs,
	input  logic                     we,
	input  logic [7:0]               db_in,
	output logic [7:0]               db_out,
	input  logic                     lp_n,
	input  logic [7:0]               col,
	input  logic [7:0]               row,
	input  logic                     vvis,
	output logic                     req_valid,
	output logic                     req_write,
	output logic [ram_addr_bits-1:0] req_addr,
	output logic [7:0]               req_data,
	input  logic                     req_ready,
	input  logic                     rsp_valid,
	input  logic [7:0]               rsp_data,
	output logic [7:0]               ht,
	output logic [7:0]               hd,
	output logic [7:0]               hp,
	output logic [3:0]               hw,
	output logic [3:0]               vw,
	output logic [7:0]               vt,
	output logic [7:0]               vd,
	output logic [7:0]               vp,
	output logic [4:0]               ctv,
	output logic [15:0]              ds,
	output vdc_video_pkg::rgbi_t     fg,
	output vdc_video_pkg::rgbi_t     bg,
	output logic [2:0]               cb
);

	logic [5:0]  sel;        // Register select
	logic [15:0] ua;         // Update address
	logic [7:0]  data_latch; // Read-ahead data
	logic        busy;
	logic        lp_flag;
	logic [7:0]  lpv;
	logic [7:0]  lph;
	logic        lp_meta;    // lp_n synchronizer
	logic        lp_last;
	logic        data_acc;   // Access to the data port
	logic [7:0]  status;
	logic [7:0]  rd_val;

	assign data_acc = cs && rs && (sel == vdc_reg_pkg::reg_data) && !busy;

	always_comb begin
		status = 8'h00;
		status[vdc_reg_pkg::st_ready] = !busy;
		status[vdc_reg_pkg::st_lp] = lp_flag;
		status[vdc_reg_pkg::st_vblank] = !vvis;
	end

	always_comb begin
		case (sel)
			vdc_reg_pkg::reg_ht:     rd_val = ht;
			vdc_reg_pkg::reg_hd:     rd_val = hd;
			vdc_reg_pkg::reg_hp:     rd_val = hp;
			vdc_reg_pkg::reg_sw:     rd_val = {vw, hw};
			vdc_reg_pkg::reg_vt:     rd_val = vt;
			vdc_reg_pkg::reg_vd:     rd_val = vd;
			vdc_reg_pkg::reg_vp:     rd_val = vp;
			vdc_reg_pkg::reg_ctv:    rd_val = {3'b000, ctv};
			vdc_reg_pkg::reg_ds_hi:  rd_val = ds[15:8];
			vdc_reg_pkg::reg_ds_lo:  rd_val = ds[7:0];
			vdc_reg_pkg::reg_lpv:    rd_val = lpv;
			vdc_reg_pkg::reg_lph:    rd_val = lph;
			vdc_reg_pkg::reg_ua_hi:  rd_val = ua[15:8];
			vdc_reg_pkg::reg_ua_lo:  rd_val = ua[7:0];
			vdc_reg_pkg::reg_colour: rd_val = {fg, bg};
			vdc_reg_pkg::reg_cb:     rd_val = {cb, 5'b00000};
			vdc_reg_pkg::reg_data:   rd_val = data_latch; // Filled by the previous access
			default:                 rd_val = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
			{ht, hd, hp, vt, vd, vp} <= '0;
			{hw, vw, ctv} <= '0;
			ds <= '0;
			{fg, bg, cb} <= '0;
			ua <= '0;
			busy <= 1'b0;
			req_valid <= 1'b0;
			lp_flag <= 1'b0;
			lpv <= '0;
			lph <= '0;
			lp_meta <= 1'b0;
			lp_last <= 1'b0;
		end else begin
			if (cs && we && !rs) begin
				sel <= db_in[5:0];
			end
			if (cs && we && rs) begin
				case (sel)
					vdc_reg_pkg::reg_ht:     ht <= db_in;
					vdc_reg_pkg::reg_hd:     hd <= db_in;
					vdc_reg_pkg::reg_hp:     hp <= db_in;
					vdc_reg_pkg::reg_sw:     {vw, hw} <= db_in;
					vdc_reg_pkg::reg_vt:     vt <= db_in;
					vdc_reg_pkg::reg_vd:     vd <= db_in;
					vdc_reg_pkg::reg_vp:     vp <= db_in;
					vdc_reg_pkg::reg_ctv:    ctv <= db_in[4:0];
					vdc_reg_pkg::reg_ds_hi:  ds[15:8] <= db_in;
					vdc_reg_pkg::reg_ds_lo:  ds[7:0] <= db_in;
					vdc_reg_pkg::reg_ua_hi:  ua[15:8] <= db_in;
					vdc_reg_pkg::reg_ua_lo:  ua[7:0] <= db_in;
					vdc_reg_pkg::reg_colour: {fg, bg} <= db_in;
					vdc_reg_pkg::reg_cb:     cb <= db_in[7:5];
					default: ;                                    // Read-only or absent
				endcase
			end
			if (cs && !we && rs && (sel == vdc_reg_pkg::reg_lpv || sel == vdc_reg_pkg::reg_lph)) begin
				lp_flag <= 1'b0; // Reading the position rearms the pen
			end
			if (data_acc) begin
				req_valid <= 1'b1;
				busy <= 1'b1;
			end
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
				if (req_write) begin
					ua <= ua + 16'd1; // Write is done at the transfer
					busy <= 1'b0;
				end
			end
			if (rsp_valid) begin
				ua <= ua + 16'd1;
				busy <= 1'b0;
			end
			lp_meta <= lp_n;
			lp_last <= lp_meta;
			if (lp_meta && !lp_last && !lp_flag) begin // Rising edge of lp_n
				lph <= col;
				lpv <= row;
				lp_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_acc) begin
			req_write <= we;
			req_addr <= ua[ram_addr_bits-1:0];
			req_data <= db_in;
		end
		if (rsp_valid) begin
			data_latch <= rsp_data;
		end
		if (cs && !we) begin
			db_out <= rs ? (rd_val | vdc_reg_pkg::read_mask[sel]) : status;
		end
	end

endmodule

//--- vdc_stim.txt
// op addr value: 1 register write, 2 register read with expected value,
// 3 RAM write at addr, 4 RAM read with expected value, 0 end of list
1 0000 000f
1 0001 0008
1 0002 000a
1 0003 0012
1 0004 0005
1 0006 0004
1 0007 0004
1 0009 0003
1 000c 0000
1 000d 0000
1 001a 009e
1 001c 0020
2 0000 000f
2 0003 0012
2 0009 00e3
2 001c 003f
2 001a 009e
2 0005 00ff
3 0800 005a
3 0801 00c3
3 0802 0017
4 0800 005a
4 0801 00c3
4 0802 0017
0 0000 0000

//--- vdc_timing.sv
/* Raster counters and sync */
`timescale 1ns/10ps

module vdc_timing (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [7:0]            ht,
	input  logic [7:0]            hd,
	input  logic [7:0]            hp,
	input  logic [3:0]            hw,
	input  logic [7:0]            vt,
	input  logic [7:0]            vd,
	input  logic [7:0]            vp,
	input  logic [3:0]            vw,
	input  logic [4:0]            ctv,
	output logic [7:0]            col,
	output logic [7:0]            row,
	output vdc_video_pkg::pixel_t pixel,
	output logic [4:0]            line,
	output logic [4:0]            next_line,
	output logic [7:0]            next_row,
	output logic                  line_start,
	output logic                  hvis,
	output logic                  vvis,
	output logic                  hsync_raw,
	output logic                  vsync_raw
);

	logic       pix_end;   // Last pixel of a cell
	logic       line_end;  // Last pixel of a scan line
	logic       last_line;
	logic       last_row;
	logic [3:0] vs_cnt;    // Remaining vsync lines
	logic [8:0] hs_end;

	assign pix_end = pixel == vdc_video_pkg::pixel_t'(vdc_video_pkg::char_width - 1);
	assign line_end = pix_end && (col >= ht);
	assign last_line = line >= ctv;
	assign last_row = row >= vt;
	assign next_line = last_line ? 5'd0 : line + 5'd1;
	assign next_row = !last_line ? row : (last_row ? 8'd0 : row + 8'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			pixel <= '0;
			col <= '0;
			line <= '0;
			row <= '0;
			vs_cnt <= '0;
		end else begin
			pixel <= pix_end ? '0 : pixel + 1'b1;
			if (line_end) begin
				col <= '0;
				line <= next_line;
				row <= next_row;
				if (next_row == vp && next_line == 5'd0) begin
					vs_cnt <= vw; // Sync starts with the row's first line
				end else if (vs_cnt != 4'd0) begin
					vs_cnt <= vs_cnt - 4'd1;
				end
			end else if (pix_end) begin
				col <= col + 8'd1;
			end
		end
	end

	assign hs_end = {1'b0, hp} + {5'b00000, hw};
	assign line_start = (col == hd) && (pixel == '0); // First blank clock
	assign hvis = col < hd;
	assign vvis = row < vd;
	assign hsync_raw = (col >= hp) && ({1'b0, col} < hs_end); // hw cells from hp
	assign vsync_raw = vs_cnt != 4'd0;

endmodule

//--- vdc_top.sv
/* Character display controller */
`timescale 1ns/10ps

module vdc_top #(
	parameter int ram_addr_bits = vdc_video_pkg::ram_addr_bits,
	parameter int max_cols = 32
)(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cs,
	input  logic                 rs,
	input  logic                 we,
	input  logic                 lp_n,
	input  logic [7:0]           db_in,
	output logic [7:0]           db_out,
	output vdc_video_pkg::rgbi_t rgbi,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 hblank,
	output logic                 vblank
);

	logic [7:0]                  ht, hd, hp, vt, vd, vp;
	logic [3:0]                  hw, vw;
	logic [4:0]                  ctv;
	logic [15:0]                 ds;
	vdc_video_pkg::rgbi_t        fg, bg;
	logic [2:0]                  cb;
	logic [7:0]                  col, row;
	vdc_video_pkg::pixel_t       pixel;
	logic [4:0]                  line, next_line;
	logic [7:0]                  next_row;
	logic                        line_start, hvis, vvis, hsync_raw, vsync_raw;
	logic                        req_valid, req_write, req_ready, rsp_valid;
	logic [ram_addr_bits-1:0]    req_addr;
	logic [7:0]                  req_data, rsp_data, wr_data;
	logic                        code_wr, bmp_wr;
	logic [$clog2(max_cols)-1:0] wr_idx, code_idx;
	vdc_video_pkg::code_t        code_rd;
	vdc_video_pkg::bitmap_t      bmp;

	vdc_regs #(.ram_addr_bits(ram_addr_bits)) regs_i (
		.clk(clk), .reset(reset), .cs(cs), .rs(rs), .we(we), .db_in(db_in),
		.db_out(db_out), .lp_n(lp_n), .col(col), .row(row), .vvis(vvis),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_data(req_data), .req_ready(req_ready), .rsp_valid(rsp_valid),
		.rsp_data(rsp_data), .ht(ht), .hd(hd), .hp(hp), .hw(hw), .vw(vw),
		.vt(vt), .vd(vd), .vp(vp), .ctv(ctv), .ds(ds), .fg(fg), .bg(bg), .cb(cb)
	);

	vdc_timing timing_i (
		.clk(clk), .reset(reset), .ht(ht), .hd(hd), .hp(hp), .hw(hw),
		.vt(vt), .vd(vd), .vp(vp), .vw(vw), .ctv(ctv), .col(col), .row(row),
		.pixel(pixel), .line(line), .next_line(next_line), .next_row(next_row),
		.line_start(line_start), .hvis(hvis), .vvis(vvis),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
	);

	vdc_fetch_fsm #(.ram_addr_bits(ram_addr_bits), .max_cols(max_cols)) fetch_i (
		.clk(clk), .reset(reset), .line_start(line_start), .next_line(next_line),
		.next_row(next_row), .hd(hd), .ds(ds), .cb(cb), .req_valid(req_valid),
		.req_write(req_write), .req_addr(req_addr), .req_data(req_data),
		.req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
		.code_wr(code_wr), .bmp_wr(bmp_wr), .wr_idx(wr_idx), .code_idx(code_idx),
		.wr_data(wr_data), .code_rd(code_rd)
	);

	// Screen codes of the coming line
	vdc_line_buf #(.item_t(vdc_video_pkg::code_t), .max_cols(max_cols)) code_buf_i (
		.clk(clk), .wr_en(code_wr), .wr_idx(wr_idx), .wr_data(wr_data),
		.rd_idx(code_idx), .rd_data(code_rd)
	);

	// Glyph bytes, read by the raster column
	vdc_line_buf #(.item_t(vdc_video_pkg::bitmap_t), .max_cols(max_cols)) bmp_buf_i (
		.clk(clk), .wr_en(bmp_wr), .wr_idx(wr_idx), .wr_data(wr_data),
		.rd_idx(col[$clog2(max_cols)-1:0]), .rd_data(bmp)
	);

	vdc_pixel_out pixel_i (
		.clk(clk), .reset(reset), .pixel(pixel), .hvis(hvis), .vvis(vvis),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .bmp(bmp), .fg(fg), .bg(bg),
		.rgbi(rgbi), .hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank)
	);

endmodule

//--- vdc_video_pkg.sv
/* Video data types */
package vdc_video_pkg;

	localparam int char_width = 8;     // Pixels per character cell
	localparam int ram_addr_bits = 14; // 16K video RAM

	typedef logic [$clog2(char_width)-1:0] pixel_t; // Pixel index in a cell
	typedef logic [3:0] rgbi_t;                     // Red, green, blue, intensity
	typedef logic [7:0] code_t;                     // Screen code
	typedef logic [char_width-1:0] bitmap_t;        // One glyph scan line, MSB first

endpackage

//--- vdc_vram.sv
/* Video RAM */
`timescale 1ns/10ps

module vdc_vram #(
	parameter int ram_addr_bits = 14
)(
	input  logic                     clk,
	input  logic                     we,
	input  logic [ram_addr_bits-1:0] addr,
	input  logic [7:0]               wdata,
	output logic [7:0]               rdata
);

	logic [7:0] mem [2**ram_addr_bits];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr]; // Old contents on a write cycle
	end

endmodule
